//--- Bender.yml
package:
  name: key_dist

sources:
  # packages first, the TLV formats use the sizing package
  - common/kme_cfg_pkg.sv
  - common/kme_tlv_pkg.sv
  - common/tlv_link_if.sv
  - rtl/kme_tlv_fifo.sv
  - key_split/key_tlv_split.sv
  - key_split/key_dist_top.sv

  - target: test
    include_dirs:
      - bench
    files:
      - bench/key_dist_tb.sv

//--- all.f
+incdir+bench
common/kme_cfg_pkg.sv
common/kme_tlv_pkg.sv
common/tlv_link_if.sv
rtl/kme_tlv_fifo.sv
key_split/key_tlv_split.sv
key_split/key_dist_top.sv
bench/key_dist_tb.sv

//--- bench/key_dist_vectors.svh
/*
 * Key TLV stimulus table for the key distribution testbench
 * One entry per TLV with the engine id of word 0, the length in words,
 * the suppress flag and the engine the TLV is expected on. An unknown
 * id stays on the engine of the TLV before it, engine 0 after reset
 */

`ifndef KEY_DIST_VECTORS_SVH
`define KEY_DIST_VECTORS_SVH

typedef struct {
    logic [3:0] eng_id;
    int         len;
    logic       suppress;
    int         exp_eng;
} tlv_vec_t;

localparam int NUM_TLVS   = 21;
localparam int HOLD_ENG   = 1;      // this engine takes nothing from HOLD_FIRST to the end
localparam int HOLD_FIRST = 14;

// each entry gives the eng_id, the length in words, suppress and the expected engine
// a suppressed TLV still moves the engine select, so its engine is listed too
tlv_vec_t tlv_table [NUM_TLVS] = '{
    '{4'hf, 2, 1'b0, 0},    // unknown id right after reset
    '{4'h4, 3, 1'b0, 0},
    '{4'h5, 1, 1'b0, 1},
    '{4'h6, 4, 1'b0, 2},
    '{4'h7, 2, 1'b0, 3},
    '{4'h2, 3, 1'b0, 3},    // unknown id keeps engine 3
    '{4'h5, 5, 1'b1, 1},
    '{4'h0, 2, 1'b0, 1},    // follows the suppressed TLV's engine
    '{4'h7, 6, 1'b0, 3},    // longer than the engine queue
    '{4'h6, 3, 1'b1, 2},
    '{4'h4, 8, 1'b0, 0},
    '{4'h9, 1, 1'b0, 0},
    '{4'h6, 1, 1'b0, 2},
    '{4'h7, 2, 1'b0, 3},
    '{4'h5, 1, 1'b0, 1},    // lands on the held engine
    '{4'h4, 4, 1'b0, 0},
    '{4'h6, 2, 1'b0, 2},
    '{4'h7, 5, 1'b0, 3},
    '{4'h8, 2, 1'b0, 3},
    '{4'h4, 2, 1'b1, 0},
    '{4'h6, 3, 1'b0, 2}
};

`endif

//--- bench/key_dist_tb.sv
/*
 * Testbench for the key distribution top level
 * Drives the TLVs of a table into the input queue, acks the engine
 * queues with LFSR back-pressure and checks every word taken against
 * a queue of expected words per engine
 */

`timescale 1ns/100ps
`default_nettype none

module key_dist_tb;

    localparam int              CLK_PERIOD   = 40;
    localparam int              RESET_CYCLES = 16;
    localparam int              NENG         = kme_cfg_pkg::NUM_ENGINES;
    localparam logic [15:0]     LFSR_SEED    = 16'd42627;

    logic                                       clk;
    logic                                       rst_n;
    logic                                       suppress_key_tlvs;
    logic                                       in_wr;
    logic [kme_cfg_pkg::TDATA_W-1:0]            in_tdata;
    logic                                       in_sot;
    logic                                       in_eot;
    logic                                       in_full;
    logic [NENG-1:0]                            eng_valid;
    logic [NENG-1:0][kme_cfg_pkg::TDATA_W-1:0]  eng_tdata;
    logic [NENG-1:0]                            eng_tlast;
    logic [NENG-1:0]                            eng_ack;

    logic [15:0] stim_lfsr;
    logic [15:0] ack_lfsr;
    logic [63:0] ack_bits;
    logic        hold_active;

    // each engine queues its expected words as {tlast, tdata}
    // and a tag of tlv * 256 + word for the error lines
    logic [64:0] exp_word_q [NENG][$];
    int          exp_tag_q  [NENG][$];

    `include "key_dist_vectors.svh"

    key_dist_top u_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .suppress_key_tlvs (suppress_key_tlvs),
        .in_wr             (in_wr),
        .in_tdata          (in_tdata),
        .in_sot            (in_sot),
        .in_eot            (in_eot),
        .in_full           (in_full),
        .eng_valid         (eng_valid),
        .eng_tdata         (eng_tdata),
        .eng_tlast         (eng_tlast),
        .eng_ack           (eng_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // taps of x^16 + x^14 + x^13 + x^11 + 1 with the register shifting right
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[0] ^ state[2] ^ state[3] ^ state[5], state[15:1]};
    endfunction

    function automatic logic [63:0] take_bits(inout logic [15:0] state, input int n);
        logic [63:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits  = {bits[62:0], state[0]};
            state = lfsr_next(state);
        end
        return bits;
    endfunction

    function automatic logic all_drained();
        logic empty;
        empty = 1'b1;
        for (int e = 0; e < NENG; e++) begin
            if (exp_word_q[e].size() != 0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_idle_outputs(input string name);
        assert (!in_full && eng_valid == '0) else begin
            $display("CHECK FAILED: %s expected %h actual %h", name,
                     {1'b0, {NENG{1'b0}}}, {in_full, eng_valid});
            abort_run();
        end
    endtask

    task automatic check_word(input int e);
        logic [64:0] exp_w;
        int          tag;
        string       name;
        assert (exp_word_q[e].size() != 0) else begin
            $display("engine %0d delivered word %h although no TLV was routed to it",
                     e, eng_tdata[e]);
            abort_run();
        end
        exp_w = exp_word_q[e].pop_front();
        tag   = exp_tag_q[e].pop_front();
        name  = $sformatf("tlv %0d word %0d engine %0d", tag / 256, tag % 256, e);
        assert (eng_tdata[e] == exp_w[63:0]) else begin
            $display("CHECK FAILED: %s tdata expected %h actual %h",
                     name, exp_w[63:0], eng_tdata[e]);
            abort_run();
        end
        assert (eng_tlast[e] == exp_w[64]) else begin
            $display("CHECK FAILED: %s tlast expected %b actual %b",
                     name, exp_w[64], eng_tlast[e]);
            abort_run();
        end
    endtask

    // holds the word until in_full was low at a rising edge
    task automatic drive_word(input logic [63:0] data, input logic sot, input logic eot);
        logic taken;
        in_wr    = 1'b1;
        in_tdata = data;
        in_sot   = sot;
        in_eot   = eot;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = !in_full;
            @(posedge clk);
            #1;
        end
        in_wr = 1'b0;
    endtask

    // the splitter reads suppress as a level, so earlier words must have left the input queue
    task automatic wait_input_idle();
        while (u_dut.key_link.valid) begin
            @(posedge clk);
            #1;
        end
    endtask

    always @(posedge clk) begin
        #1;
        ack_bits = take_bits(ack_lfsr, NENG);
        eng_ack  = ack_bits[NENG-1:0];
        if (hold_active) begin
            eng_ack[HOLD_ENG] = 1'b0;
        end
    end

    // valid and ack are stable here and the word moves at the next rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            for (int e = 0; e < NENG; e++) begin
                if (eng_valid[e] && eng_ack[e]) begin
                    check_word(e);
                end
            end
        end
    end

    initial begin : watchdog
        int total_words;
        total_words = 0;
        for (int t = 0; t < NUM_TLVS; t++) begin
            total_words += tlv_table[t].len;
        end
        #((RESET_CYCLES + 40 * total_words + 500) * CLK_PERIOD);
        $display("timeout: not every expected word came out of the engine queues in time");
        abort_run();
    end

    initial begin : stimulus
        logic [63:0] word;
        logic        last;
        int          eng;
        clk               = 1'b0;
        rst_n             = 1'b0;
        suppress_key_tlvs = 1'b0;
        in_wr             = 1'b0;
        in_tdata          = '0;
        in_sot            = 1'b0;
        in_eot            = 1'b0;
        eng_ack           = '0;
        hold_active       = 1'b0;
        stim_lfsr         = LFSR_SEED;
        ack_lfsr          = LFSR_SEED;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle_outputs("during reset");
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs("after reset");
        @(posedge clk);
        #1;

        for (int t = 0; t < NUM_TLVS; t++) begin
            if (t == HOLD_FIRST) begin
                hold_active = 1'b1;
            end
            if (tlv_table[t].suppress != suppress_key_tlvs) begin
                wait_input_idle();
                suppress_key_tlvs = tlv_table[t].suppress;
            end
            eng = tlv_table[t].exp_eng;
            for (int w = 0; w < tlv_table[t].len; w++) begin
                last = (w == tlv_table[t].len - 1);
                if (w == 0) begin
                    word = take_bits(stim_lfsr, 60);
                    word = {word[59:0], tlv_table[t].eng_id};   // id sits in the low nibble
                end else begin
                    word = take_bits(stim_lfsr, 64);
                end
                if (!tlv_table[t].suppress) begin
                    exp_word_q[eng].push_back({last, word});
                    exp_tag_q[eng].push_back(t * 256 + w);
                end
                drive_word(word, w == 0, last);
            end
        end

        // the held engine starts taking words again
        hold_active = 1'b0;
        while (!all_drained()) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        assert (eng_valid == '0 && !in_full) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("engine queues still hold words after every expected word was taken");
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- common/kme_cfg_pkg.sv
/*
 * KME key distribution sizing
 * Engine count, the id to engine mapping and the queue dimensions
 */

`default_nettype none

package kme_cfg_pkg;

    localparam int NUM_ENGINES = 4;
    localparam int ENG_SEL_W   = 2;     // index into the engine array

    // ids ENG_ID_BASE .. ENG_ID_BASE + NUM_ENGINES - 1 pick engines 0 .. NUM_ENGINES - 1
    localparam int ENG_ID_BASE = 4;

    localparam int TDATA_W = 64;

    // the input queue only has to cover the splitter's decode cycle
    localparam int IN_FIFO_DEPTH  = 2;
    localparam int ENG_FIFO_DEPTH = 4;

endpackage

`default_nettype wire

//--- common/kme_tlv_pkg.sv
/*
 * KME key TLV word formats
 * Layout of the 64-bit TLV data word, the word-0 header carrying the
 * engine id, and the payloads held by the input and engine queues
 */

`default_nettype none

package kme_tlv_pkg;

    // width of the engine id field in word 0
    localparam int ENG_ID_W = 4;

    // width of the part of word 0 that the splitter does not look at
    localparam int W0_OPAQUE_W = kme_cfg_pkg::TDATA_W - ENG_ID_W;

    // one TLV data word as it travels through the block
    typedef logic [kme_cfg_pkg::TDATA_W-1:0] tlv_word_t;

    // first word of a key TLV
    // only the engine id is decoded, everything above it passes untouched
    typedef struct packed {
        logic [W0_OPAQUE_W-1:0] opaque;
        logic [ENG_ID_W-1:0]    eng_id;     // low bits of the word
    } tlv_word0_t;

    // entry of the input queue, one decrypted TLV word with its framing
    typedef struct packed {
        tlv_word_t tdata;
        logic      sot;     // first word of a TLV
        logic      eot;     // last word of a TLV
    } key_word_t;

    // entry of a per-engine output queue
    typedef struct packed {
        tlv_word_t tdata;
        logic      tlast;   // marks the last word handed to the engine
    } engine_word_t;

endpackage

`default_nettype wire

//--- common/tlv_link_if.sv
/*
 * Internal TLV links of the key distribution block
 * key_word_if carries queued input words to the splitter with valid and ack,
 * engine_word_if carries steered words into one engine queue with wr and full
 */

`timescale 1ns/100ps
`default_nettype none

interface key_word_if;
    logic                  valid;
    kme_tlv_pkg::tlv_word_t tdata;
    logic                  sot;
    logic                  eot;
    logic                  ack;    // word moves when valid and ack are both high

    modport source (output valid, output tdata, output sot, output eot, input ack);
    modport sink   (input valid, input tdata, input sot, input eot, output ack);
endinterface

interface engine_word_if;
    logic                  wr;
    kme_tlv_pkg::tlv_word_t tdata;
    logic                  tlast;
    logic                  full;   // the writer holds off while this is high

    modport source (output wr, output tdata, output tlast, input full);
    modport sink   (input wr, input tdata, input tlast, output full);
endinterface

`default_nettype wire

//--- key_split/key_dist_top.sv
/*
 * Key distribution top level
 * Input queue for decrypted key TLV words, the splitter, and one output
 * queue per cipher engine read with valid and ack
 */

`timescale 1ns/100ps
`default_nettype none

module key_dist_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                suppress_key_tlvs,

    input  logic                                in_wr,
    input  logic [kme_cfg_pkg::TDATA_W-1:0]     in_tdata,
    input  logic                                in_sot,
    input  logic                                in_eot,
    output logic                                in_full,

    output logic [kme_cfg_pkg::NUM_ENGINES-1:0] eng_valid,
    output logic [kme_cfg_pkg::NUM_ENGINES-1:0][kme_cfg_pkg::TDATA_W-1:0] eng_tdata,
    output logic [kme_cfg_pkg::NUM_ENGINES-1:0] eng_tlast,
    input  logic [kme_cfg_pkg::NUM_ENGINES-1:0] eng_ack
);

    kme_tlv_pkg::key_word_t in_word;
    kme_tlv_pkg::key_word_t key_rd;

    key_word_if    key_link ();
    engine_word_if eng_link [kme_cfg_pkg::NUM_ENGINES] ();

    assign in_word.tdata = in_tdata;
    assign in_word.sot   = in_sot;
    assign in_word.eot   = in_eot;

    kme_tlv_fifo #(
        .payload_t (kme_tlv_pkg::key_word_t),
        .DEPTH     (kme_cfg_pkg::IN_FIFO_DEPTH)
    ) u_in_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (in_wr),
        .wdata (in_word),
        .full  (in_full),
        .valid (key_link.valid),
        .rdata (key_rd),
        .ack   (key_link.ack)
    );

    assign key_link.tdata = key_rd.tdata;
    assign key_link.sot   = key_rd.sot;
    assign key_link.eot   = key_rd.eot;

    key_tlv_split u_split (
        .clk               (clk),
        .rst_n             (rst_n),
        .suppress_key_tlvs (suppress_key_tlvs),
        .key               (key_link),
        .eng               (eng_link)
    );

    for (genvar g = 0; g < kme_cfg_pkg::NUM_ENGINES; g++) begin : g_eng_q
        kme_tlv_pkg::engine_word_t eng_wdata;
        kme_tlv_pkg::engine_word_t eng_rdata;

        assign eng_wdata.tdata = eng_link[g].tdata;
        assign eng_wdata.tlast = eng_link[g].tlast;

        kme_tlv_fifo #(
            .payload_t (kme_tlv_pkg::engine_word_t),
            .DEPTH     (kme_cfg_pkg::ENG_FIFO_DEPTH)
        ) u_eng_fifo (
            .clk   (clk),
            .rst_n (rst_n),
            .wr    (eng_link[g].wr),
            .wdata (eng_wdata),
            .full  (eng_link[g].full),
            .valid (eng_valid[g]),
            .rdata (eng_rdata),
            .ack   (eng_ack[g])
        );

        assign eng_tdata[g] = eng_rdata.tdata;
        assign eng_tlast[g] = eng_rdata.tlast;
    end

endmodule

`default_nettype wire

//--- key_split/key_tlv_split.sv
/*
 * Key TLV splitter
 * Decodes the engine id in word 0 of each TLV, then forwards every word
 * of that TLV to the chosen engine queue, or drops the whole TLV while
 * suppress_key_tlvs is high
 */

`timescale 1ns/100ps
`default_nettype none

module key_tlv_split (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 suppress_key_tlvs,

    key_word_if.sink             key,
    engine_word_if.source        eng [kme_cfg_pkg::NUM_ENGINES]
);

    typedef enum logic {
        idle_word0 = 1'b0,
        forward    = 1'b1
    } split_state_t;

    split_state_t                         state;
    split_state_t                         state_nxt;
    logic [kme_cfg_pkg::ENG_SEL_W-1:0]    eng_sel;
    logic [kme_cfg_pkg::ENG_SEL_W-1:0]    eng_sel_nxt;
    logic [kme_cfg_pkg::NUM_ENGINES-1:0]  eng_full;

    kme_tlv_pkg::tlv_word0_t              w0;
    logic [kme_tlv_pkg::ENG_ID_W-1:0]     id_off;
    logic                                 id_hit;
    logic                                 fwd_go;

    assign w0     = key.tdata;
    assign id_off = w0.eng_id - kme_tlv_pkg::ENG_ID_W'(kme_cfg_pkg::ENG_ID_BASE);
    assign id_hit = key.sot &&
                    (w0.eng_id >= kme_cfg_pkg::ENG_ID_BASE) &&
                    (w0.eng_id <  kme_cfg_pkg::ENG_ID_BASE + kme_cfg_pkg::NUM_ENGINES);

    // a word moves only once the engine is chosen and its queue has room
    assign fwd_go  = (state == forward) && key.valid && !eng_full[eng_sel];
    assign key.ack = fwd_go;

    always_comb begin
        state_nxt   = state;
        eng_sel_nxt = eng_sel;
        case (state)
            idle_word0: begin
                if (key.valid) begin
                    state_nxt = forward;
                    if (id_hit) begin
                        eng_sel_nxt = id_off[kme_cfg_pkg::ENG_SEL_W-1:0];
                    end     // unknown ids stay on the previous engine
                end
            end
            forward: begin
                if (fwd_go && key.eot) begin
                    state_nxt = idle_word0;
                end
            end
            default: state_nxt = idle_word0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= idle_word0;
            eng_sel <= '0;
        end else begin
            state   <= state_nxt;
            eng_sel <= eng_sel_nxt;
        end
    end

    // every engine sees the same data, only the selected one gets the strobe
    for (genvar g = 0; g < kme_cfg_pkg::NUM_ENGINES; g++) begin : g_eng
        assign eng_full[g] = eng[g].full;
        assign eng[g].wr    = fwd_go && !suppress_key_tlvs &&
                              (eng_sel == kme_cfg_pkg::ENG_SEL_W'(g));
        assign eng[g].tdata = key.tdata;
        assign eng[g].tlast = key.eot;
    end

endmodule

`default_nettype wire

//--- rtl/kme_tlv_fifo.sv
/*
 * Small synchronous FIFO
 * Write side uses a write strobe with full, read side shows valid and
 * takes a word on ack. Payload type is a parameter so the same queue
 * holds input words and engine words
 */

`timescale 1ns/100ps
`default_nettype none

module kme_tlv_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     wr,
    input  payload_t wdata,
    output logic     full,

    output logic     valid,
    output payload_t rdata,
    input  logic     ack
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(DEPTH));
    assign valid = (count != '0);
    assign rdata = mem[rd_ptr];

    assign push = wr && !full;      // a write into a full queue is lost
    assign pop  = ack && valid;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire
